// File: mem_pkg.sv
package mem_pkg;

    // Byte address as issued by the core
    typedef logic [31:0] addr_t;

    // One data word on the memory bus
    typedef logic [31:0] word_t;

    // One enable bit per byte lane of a word
    typedef logic [3:0] byte_en_t;

    // Two adjacent words that together hold an unaligned access
    typedef logic [63:0] dword_t;

    // Byte enables across the two words of a dword_t
    typedef logic [7:0] dbyte_en_t;

endpackage

// File: lsu_pkg.sv
package lsu_pkg;

    typedef enum logic [1:0] {
        load_idle,
        load_low,
        load_high
    } load_state_t;

    typedef enum logic [1:0] {
        store_idle,
        store_low,
        store_high
    } store_state_t;

    // Current owner of the shared memory port
    typedef enum logic [1:0] {
        grant_none,
        grant_load,
        grant_store
    } grant_t;

endpackage

// File: read_buffer.sv
`timescale 1ns/10ps

module read_buffer (
    input  logic clk,
    input  logic reset_n,

    input  logic clear,

    input  mem_pkg::word_t mem_read_data,
    input  logic mem_read_data_valid,

    output mem_pkg::dword_t data,
    output logic [1:0] count
);

    mem_pkg::word_t slot_low;
    mem_pkg::word_t slot_high;

    assign data = {slot_high, slot_low};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count <= 2'd0;
        end
        else if (clear) begin
            count <= 2'd0;
        end
        else if (mem_read_data_valid) begin
            count <= count + 2'd1;
        end
    end

    // Words come back in order, so the count picks the slot
    always_ff @(posedge clk) begin
        if (mem_read_data_valid && !clear) begin
            if (count == 2'd0) begin
                slot_low <= mem_read_data;
            end
            else begin
                slot_high <= mem_read_data;
            end
        end
    end

endmodule

// File: load_unit.sv
`timescale 1ns/10ps

module load_unit (
    input  logic clk,
    input  logic reset_n,

    output logic read_ready,
    input  logic read_req,
    input  mem_pkg::addr_t read_addr,
    input  mem_pkg::byte_en_t read_byte_enable,
    output mem_pkg::word_t read_data,
    output logic read_data_valid,

    input  logic mem_ready,
    output mem_pkg::addr_t mem_addr,
    output mem_pkg::byte_en_t mem_byte_enable,
    output logic mem_read_req,

    output logic buffer_clear,
    input  mem_pkg::dword_t buffer_data,
    input  logic [1:0] buffer_count
);

    lsu_pkg::load_state_t state;
    lsu_pkg::load_state_t state_next;

    mem_pkg::word_t read_data_next;
    logic read_data_valid_next;

    mem_pkg::addr_t mem_addr_next;
    mem_pkg::byte_en_t mem_byte_enable_next;
    logic mem_read_req_next;

    mem_pkg::dbyte_en_t word_byte_enable; // Enables spread over both words
    mem_pkg::dbyte_en_t word_byte_enable_next;

    logic [1:0] addr_low;
    logic [1:0] addr_low_next;

    assign read_ready = state == lsu_pkg::load_idle;

    // Empty the buffer as the request is taken so old words are never counted
    assign buffer_clear = read_ready && read_req;

    always_comb begin
        state_next = state;
        read_data_next = read_data;
        read_data_valid_next = 1'b0;
        mem_addr_next = mem_addr;
        mem_byte_enable_next = mem_byte_enable;
        mem_read_req_next = mem_read_req;
        word_byte_enable_next = word_byte_enable;
        addr_low_next = addr_low;

        case (state)
            lsu_pkg::load_idle: begin
                if (read_req) begin
                    addr_low_next = read_addr[1:0];
                    word_byte_enable_next = {4'h0, read_byte_enable} << read_addr[1:0];

                    mem_addr_next = {read_addr[31:2], 2'b00};
                    mem_byte_enable_next = word_byte_enable_next[3:0];
                    mem_read_req_next = 1'b1;

                    state_next = lsu_pkg::load_low;
                end
            end

            lsu_pkg::load_low: begin
                if (mem_read_req && mem_ready) begin
                    if (word_byte_enable[7:4] == 4'h0) begin
                        mem_read_req_next = 1'b0; // Whole access fits in one word
                    end
                    else begin
                        mem_addr_next = {mem_addr[31:2] + 30'd1, 2'b00};
                        mem_byte_enable_next = word_byte_enable[7:4];
                        state_next = lsu_pkg::load_high;
                    end
                end

                if (!mem_read_req_next && buffer_count == 2'd1) begin
                    read_data_next = mem_pkg::word_t'(buffer_data >> {addr_low, 3'b000});
                    read_data_valid_next = 1'b1;
                    state_next = lsu_pkg::load_idle;
                end
            end

            lsu_pkg::load_high: begin
                if (mem_read_req && mem_ready) begin
                    mem_read_req_next = 1'b0;
                end

                // Both words must be back before the result can be shifted down
                if (!mem_read_req_next && buffer_count == 2'd2) begin
                    read_data_next = mem_pkg::word_t'(buffer_data >> {addr_low, 3'b000});
                    read_data_valid_next = 1'b1;
                    state_next = lsu_pkg::load_idle;
                end
            end

            default: begin
                state_next = lsu_pkg::load_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= lsu_pkg::load_idle;
            read_data_valid <= 1'b0;
            mem_read_req <= 1'b0;
        end
        else begin
            state <= state_next;
            read_data_valid <= read_data_valid_next;
            mem_read_req <= mem_read_req_next;
        end
    end

    always_ff @(posedge clk) begin
        read_data <= read_data_next;
        mem_addr <= mem_addr_next;
        mem_byte_enable <= mem_byte_enable_next;
        word_byte_enable <= word_byte_enable_next;
        addr_low <= addr_low_next;
    end

endmodule

// File: store_unit.sv
`timescale 1ns/10ps

module store_unit (
    input  logic clk,
    input  logic reset_n,

    output logic write_ready,
    input  logic write_req,
    input  mem_pkg::addr_t write_addr,
    input  mem_pkg::byte_en_t write_byte_enable,
    input  mem_pkg::word_t write_data,
    output logic write_done,

    input  logic mem_ready,
    output mem_pkg::addr_t mem_addr,
    output mem_pkg::byte_en_t mem_byte_enable,
    output mem_pkg::word_t mem_write_data,
    output logic mem_write_req
);

    lsu_pkg::store_state_t state;
    lsu_pkg::store_state_t state_next;

    mem_pkg::dword_t shifted_data;
    mem_pkg::dbyte_en_t shifted_byte_enable;

    mem_pkg::word_t high_data; // Upper word kept for the second write
    mem_pkg::byte_en_t high_byte_enable;

    assign write_ready = state == lsu_pkg::store_idle;

    // Move the data and lanes up to their position inside the two words
    assign shifted_data = {32'h0, write_data} << {write_addr[1:0], 3'b000};
    assign shifted_byte_enable = {4'h0, write_byte_enable} << write_addr[1:0];

    always_comb begin
        state_next = state;

        case (state)
            lsu_pkg::store_idle: begin
                if (write_req) begin
                    state_next = lsu_pkg::store_low;
                end
            end

            lsu_pkg::store_low: begin
                if (mem_ready) begin
                    if (high_byte_enable == 4'h0) begin
                        state_next = lsu_pkg::store_idle;
                    end
                    else begin
                        state_next = lsu_pkg::store_high;
                    end
                end
            end

            lsu_pkg::store_high: begin
                if (mem_ready) begin
                    state_next = lsu_pkg::store_idle;
                end
            end

            default: begin
                state_next = lsu_pkg::store_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= lsu_pkg::store_idle;
            mem_write_req <= 1'b0;
            write_done <= 1'b0;
        end
        else begin
            state <= state_next;
            mem_write_req <= state_next != lsu_pkg::store_idle;
            write_done <= state != lsu_pkg::store_idle && state_next == lsu_pkg::store_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (write_ready && write_req) begin
            mem_addr <= {write_addr[31:2], 2'b00};
            mem_byte_enable <= shifted_byte_enable[3:0];
            mem_write_data <= shifted_data[31:0];
            high_data <= shifted_data[63:32];
            high_byte_enable <= shifted_byte_enable[7:4];
        end
        else if (state == lsu_pkg::store_low && mem_ready && high_byte_enable != 4'h0) begin
            mem_addr <= {mem_addr[31:2] + 30'd1, 2'b00};
            mem_byte_enable <= high_byte_enable;
            mem_write_data <= high_data;
        end
    end

endmodule

// File: mem_port_arbiter.sv
`timescale 1ns/10ps

module mem_port_arbiter (
    input  logic clk,
    input  logic reset_n,

    input  logic load_mem_read_req,
    input  mem_pkg::addr_t load_mem_addr,
    input  mem_pkg::byte_en_t load_mem_byte_enable,
    output logic load_mem_ready,

    input  logic store_mem_write_req,
    input  mem_pkg::addr_t store_mem_addr,
    input  mem_pkg::byte_en_t store_mem_byte_enable,
    input  mem_pkg::word_t store_mem_write_data,
    output logic store_mem_ready,

    input  logic mem_ready,
    output mem_pkg::addr_t mem_addr,
    output mem_pkg::byte_en_t mem_byte_enable,
    output logic mem_read_req,
    output logic mem_write_req,
    output mem_pkg::word_t mem_write_data
);

    lsu_pkg::grant_t grant; // Owner from the previous cycle
    lsu_pkg::grant_t owner;

    // The owner keeps the port while it still requests, otherwise the load side wins
    always_comb begin
        if (grant == lsu_pkg::grant_load && load_mem_read_req) begin
            owner = lsu_pkg::grant_load;
        end
        else if (grant == lsu_pkg::grant_store && store_mem_write_req) begin
            owner = lsu_pkg::grant_store;
        end
        else if (load_mem_read_req) begin
            owner = lsu_pkg::grant_load;
        end
        else if (store_mem_write_req) begin
            owner = lsu_pkg::grant_store;
        end
        else begin
            owner = lsu_pkg::grant_none;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grant <= lsu_pkg::grant_none;
        end
        else begin
            grant <= owner;
        end
    end

    assign load_mem_ready = mem_ready && owner == lsu_pkg::grant_load;
    assign store_mem_ready = mem_ready && owner == lsu_pkg::grant_store;

    always_comb begin
        mem_addr = '0;
        mem_byte_enable = '0;
        mem_read_req = 1'b0;
        mem_write_req = 1'b0;
        mem_write_data = '0;

        case (owner)
            lsu_pkg::grant_load: begin
                mem_addr = load_mem_addr;
                mem_byte_enable = load_mem_byte_enable;
                mem_read_req = load_mem_read_req;
            end
            lsu_pkg::grant_store: begin
                mem_addr = store_mem_addr;
                mem_byte_enable = store_mem_byte_enable;
                mem_write_req = store_mem_write_req;
                mem_write_data = store_mem_write_data;
            end
            default: begin
                mem_addr = '0; // Port idles at zero
            end
        endcase
    end

endmodule

// File: load_store_unit.sv
`timescale 1ns/10ps

module load_store_unit (
    input  logic clk,
    input  logic reset_n,

    output logic read_ready,
    input  logic read_req,
    input  mem_pkg::addr_t read_addr,
    input  mem_pkg::byte_en_t read_byte_enable,
    output mem_pkg::word_t read_data,
    output logic read_data_valid,

    output logic write_ready,
    input  logic write_req,
    input  mem_pkg::addr_t write_addr,
    input  mem_pkg::byte_en_t write_byte_enable,
    input  mem_pkg::word_t write_data,
    output logic write_done,

    input  logic mem_ready,
    output mem_pkg::addr_t mem_addr,
    output mem_pkg::byte_en_t mem_byte_enable,
    output logic mem_read_req,
    output logic mem_write_req,
    output mem_pkg::word_t mem_write_data,
    input  mem_pkg::word_t mem_read_data,
    input  logic mem_read_data_valid
);

    logic load_mem_ready;
    logic load_mem_read_req;
    mem_pkg::addr_t load_mem_addr;
    mem_pkg::byte_en_t load_mem_byte_enable;

    logic store_mem_ready;
    logic store_mem_write_req;
    mem_pkg::addr_t store_mem_addr;
    mem_pkg::byte_en_t store_mem_byte_enable;
    mem_pkg::word_t store_mem_write_data;

    logic buffer_clear;
    mem_pkg::dword_t buffer_data;
    logic [1:0] buffer_count;

    load_unit load_unit0 (
        .clk(clk),
        .reset_n(reset_n),
        .read_ready(read_ready),
        .read_req(read_req),
        .read_addr(read_addr),
        .read_byte_enable(read_byte_enable),
        .read_data(read_data),
        .read_data_valid(read_data_valid),
        .mem_ready(load_mem_ready),
        .mem_addr(load_mem_addr),
        .mem_byte_enable(load_mem_byte_enable),
        .mem_read_req(load_mem_read_req),
        .buffer_clear(buffer_clear),
        .buffer_data(buffer_data),
        .buffer_count(buffer_count)
    );

    store_unit store_unit0 (
        .clk(clk),
        .reset_n(reset_n),
        .write_ready(write_ready),
        .write_req(write_req),
        .write_addr(write_addr),
        .write_byte_enable(write_byte_enable),
        .write_data(write_data),
        .write_done(write_done),
        .mem_ready(store_mem_ready),
        .mem_addr(store_mem_addr),
        .mem_byte_enable(store_mem_byte_enable),
        .mem_write_data(store_mem_write_data),
        .mem_write_req(store_mem_write_req)
    );

    // Read data bypasses the arbiter since only the load side reads
    read_buffer read_buffer0 (
        .clk(clk),
        .reset_n(reset_n),
        .clear(buffer_clear),
        .mem_read_data(mem_read_data),
        .mem_read_data_valid(mem_read_data_valid),
        .data(buffer_data),
        .count(buffer_count)
    );

    mem_port_arbiter mem_port_arbiter0 (
        .clk(clk),
        .reset_n(reset_n),
        .load_mem_read_req(load_mem_read_req),
        .load_mem_addr(load_mem_addr),
        .load_mem_byte_enable(load_mem_byte_enable),
        .load_mem_ready(load_mem_ready),
        .store_mem_write_req(store_mem_write_req),
        .store_mem_addr(store_mem_addr),
        .store_mem_byte_enable(store_mem_byte_enable),
        .store_mem_write_data(store_mem_write_data),
        .store_mem_ready(store_mem_ready),
        .mem_ready(mem_ready),
        .mem_addr(mem_addr),
        .mem_byte_enable(mem_byte_enable),
        .mem_read_req(mem_read_req),
        .mem_write_req(mem_write_req),
        .mem_write_data(mem_write_data)
    );

endmodule

// File: tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model #(
    parameter int word_count = 256,
    parameter int random_seed = 1
) (
    input  logic clk,
    output logic mem_ready,
    input  mem_pkg::addr_t mem_addr,
    input  mem_pkg::byte_en_t mem_byte_enable,
    input  logic mem_read_req,
    input  logic mem_write_req,
    input  mem_pkg::word_t mem_write_data,
    output mem_pkg::word_t mem_read_data,
    output logic mem_read_data_valid
);

    mem_pkg::word_t words [0:word_count-1];
    mem_pkg::word_t return_data_q[$]; // Reads waiting to come back, oldest first
    int return_cycle_q[$];
    int cycle;
    int last_return;

    initial begin
        int i;
        int k;
        int a;
        int index;
        int due;

        void'($urandom(random_seed));
        for (i = 0; i < word_count; i++) begin
            for (k = 0; k < 4; k++) begin
                a = 4 * i + k;
                words[i][8 * k +: 8] = a[7:0] ^ {4{a[9:8]}} ^ 8'h96;
            end
        end
        cycle = 0;
        last_return = 0;
        mem_ready = 1'b0;
        mem_read_data = '0;
        mem_read_data_valid = 1'b0;

        forever begin
            @(posedge clk);
            cycle = cycle + 1;
            #1;
            mem_ready = ($urandom % 100) < 70; // Ready in about 70 % of the cycles
            if (return_cycle_q.size() > 0 && return_cycle_q[0] <= cycle) begin
                mem_read_data = return_data_q.pop_front();
                void'(return_cycle_q.pop_front());
                mem_read_data_valid = 1'b1;
            end
            else begin
                mem_read_data_valid = 1'b0;
            end

            // Port signals are settled by mid-cycle and hold until the next edge
            @(negedge clk);
            index = (mem_addr >> 2) % word_count;
            if (mem_ready && mem_write_req) begin
                for (k = 0; k < 4; k++) begin
                    if (mem_byte_enable[k]) begin
                        words[index][8 * k +: 8] = mem_write_data[8 * k +: 8];
                    end
                end
            end
            else if (mem_ready && mem_read_req) begin
                due = cycle + 1 + ($urandom % 4);
                if (due <= last_return) begin
                    due = last_return + 1; // Keeps returns in order
                end
                last_return = due;
                return_data_q.push_back(words[index]);
                return_cycle_q.push_back(due);
            end
        end
    end

endmodule

// File: tb_load_store_unit.sv
`timescale 1ns/10ps

module tb_load_store_unit;

    localparam int mem_words = 256;
    localparam int random_seed = 93998;

    logic clk;
    logic reset_n;

    logic read_ready;
    logic read_req;
    mem_pkg::addr_t read_addr;
    mem_pkg::byte_en_t read_byte_enable;
    mem_pkg::word_t read_data;
    logic read_data_valid;

    logic write_ready;
    logic write_req;
    mem_pkg::addr_t write_addr;
    mem_pkg::byte_en_t write_byte_enable;
    mem_pkg::word_t write_data;
    logic write_done;

    logic mem_ready;
    mem_pkg::addr_t mem_addr;
    mem_pkg::byte_en_t mem_byte_enable;
    logic mem_read_req;
    logic mem_write_req;
    mem_pkg::word_t mem_write_data;
    mem_pkg::word_t mem_read_data;
    logic mem_read_data_valid;

    logic [7:0] shadow [0:4*mem_words-1]; // What memory should hold, byte by byte

    logic [7:0] op_q[$];
    logic [31:0] addr_q[$];
    logic [3:0] be_q[$];
    logic [31:0] data_q[$];

    int cycle_count;
    int cycle_limit;
    int check_count;
    int mismatch_count;
    int other_count;
    int valid_count;
    int done_count;
    int loads_issued;
    int stores_issued;

    load_store_unit dut (
        .clk(clk),
        .reset_n(reset_n),
        .read_ready(read_ready),
        .read_req(read_req),
        .read_addr(read_addr),
        .read_byte_enable(read_byte_enable),
        .read_data(read_data),
        .read_data_valid(read_data_valid),
        .write_ready(write_ready),
        .write_req(write_req),
        .write_addr(write_addr),
        .write_byte_enable(write_byte_enable),
        .write_data(write_data),
        .write_done(write_done),
        .mem_ready(mem_ready),
        .mem_addr(mem_addr),
        .mem_byte_enable(mem_byte_enable),
        .mem_read_req(mem_read_req),
        .mem_write_req(mem_write_req),
        .mem_write_data(mem_write_data),
        .mem_read_data(mem_read_data),
        .mem_read_data_valid(mem_read_data_valid)
    );

    tb_mem_model #(
        .word_count(mem_words),
        .random_seed(random_seed)
    ) mem_model (
        .clk(clk),
        .mem_ready(mem_ready),
        .mem_addr(mem_addr),
        .mem_byte_enable(mem_byte_enable),
        .mem_read_req(mem_read_req),
        .mem_write_req(mem_write_req),
        .mem_write_data(mem_write_data),
        .mem_read_data(mem_read_data),
        .mem_read_data_valid(mem_read_data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Counted mid-cycle where the strobes are stable
    always @(negedge clk) begin
        if (reset_n && read_data_valid) valid_count = valid_count + 1;
        if (reset_n && write_done) done_count = done_count + 1;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count = check_count + 1;
        if (actual !== expected) begin
            mismatch_count = mismatch_count + 1;
            $display("FAIL %0t %s: actual %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic init_shadow;
        int a;
        for (a = 0; a < 4 * mem_words; a++) begin
            shadow[a] = a[7:0] ^ {4{a[9:8]}} ^ 8'h96;
        end
    endtask

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    // Byte k of an access lives at address + k
    function automatic logic [31:0] shadow_read(input logic [31:0] addr, input logic [3:0] be);
        logic [31:0] value;
        logic [31:0] byte_addr;
        int k;
        value = '0;
        for (k = 0; k < 4; k++) begin
            byte_addr = addr + k;
            if (be[k]) value[8 * k +: 8] = shadow[byte_addr[9:0]];
        end
        return value;
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input logic [3:0] be,
                                input logic [31:0] data);
        logic [31:0] byte_addr;
        int k;
        for (k = 0; k < 4; k++) begin
            byte_addr = addr + k;
            if (be[k]) shadow[byte_addr[9:0]] = data[8 * k +: 8];
        end
    endtask

    // Lanes of one memory word that a load at addr with enables be touches
    function automatic logic [3:0] load_lanes(input logic [31:0] addr, input logic [3:0] be,
                                              input logic [31:0] word_addr);
        logic [3:0] lanes;
        logic [31:0] byte_addr;
        int k;
        lanes = '0;
        for (k = 0; k < 4; k++) begin
            byte_addr = addr + k;
            if (be[k] && byte_addr[31:2] == word_addr[31:2]) lanes[byte_addr[1:0]] = 1'b1;
        end
        return lanes;
    endfunction

    // Port transfers are checked mid-cycle where the arbiter outputs have settled
    always @(negedge clk) begin
        if (reset_n && mem_ready && (mem_read_req || mem_write_req)) begin
            check_value("mem_addr[1:0]", 32'(mem_addr[1:0]), 32'd0);
        end
        if (reset_n && mem_ready && mem_read_req) begin
            check_value("mem_byte_enable", 32'(mem_byte_enable),
                        32'(load_lanes(read_addr, read_byte_enable, mem_addr)));
        end
    end

    task automatic load_input;
        int fd;
        int code;
        int line_no;
        logic [7:0] op;
        logic [31:0] addr;
        logic [3:0] be;
        logic [31:0] data;
        logic [8*128-1:0] rest_of_line;
        fd = $fopen("lsu_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open lsu_input.txt for reading");
            other_count = other_count + 1;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) break;
            line_no = line_no + 1;
            if (op == "#") begin
                code = $fgets(rest_of_line, fd);
            end
            else begin
                code = $fscanf(fd, "%h %h %h", addr, be, data);
                if (code != 3 || !(op == "L" || op == "S" || op == "P")) begin
                    $display("Line %0d of lsu_input.txt is not a valid access", line_no);
                    other_count = other_count + 1;
                    code = $fgets(rest_of_line, fd);
                end
                else begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    be_q.push_back(be);
                    data_q.push_back(data);
                end
            end
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            $display("lsu_input.txt holds no accesses");
            other_count = other_count + 1;
        end
    endtask

    task automatic step;
        @(posedge clk);
        #1;
    endtask

    task automatic check_load(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] file_data);
        logic [31:0] mask;
        mask = lane_mask(be);
        check_value("read_data", read_data & mask, shadow_read(addr, be));
        check_value("read_data (file)", read_data & mask, file_data & mask);
    endtask

    task automatic issue_load(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] file_data);
        while (!read_ready) step();
        read_req = 1'b1;
        read_addr = addr;
        read_byte_enable = be;
        step();
        read_req = 1'b0;
        while (!read_data_valid) step();
        check_load(addr, be, file_data);
        loads_issued = loads_issued + 1;
    endtask

    task automatic issue_store(input logic [31:0] addr, input logic [3:0] be,
                               input logic [31:0] data);
        while (!write_ready) step();
        write_req = 1'b1;
        write_addr = addr;
        write_byte_enable = be;
        write_data = data;
        step();
        write_req = 1'b0;
        while (!write_done) step();
        shadow_write(addr, be, data);
        stores_issued = stores_issued + 1;
    endtask

    // The two accesses touch different words, so their order does not matter
    task automatic issue_pair(input int store_index, input int load_index);
        logic load_seen;
        logic store_seen;
        while (!(read_ready && write_ready)) step();
        read_req = 1'b1;
        read_addr = addr_q[load_index];
        read_byte_enable = be_q[load_index];
        write_req = 1'b1;
        write_addr = addr_q[store_index];
        write_byte_enable = be_q[store_index];
        write_data = data_q[store_index];
        step();
        read_req = 1'b0;
        write_req = 1'b0;
        load_seen = 1'b0;
        store_seen = 1'b0;
        while (!(load_seen && store_seen)) begin
            if (read_data_valid && !load_seen) begin
                load_seen = 1'b1;
                check_load(addr_q[load_index], be_q[load_index], data_q[load_index]);
            end
            if (write_done) store_seen = 1'b1;
            step();
        end
        shadow_write(addr_q[store_index], be_q[store_index], data_q[store_index]);
        loads_issued = loads_issued + 1;
        stores_issued = stores_issued + 1;
    endtask

    task automatic run_accesses;
        int i;
        i = 0;
        while (i < op_q.size()) begin
            case (op_q[i])
                "L": begin
                    issue_load(addr_q[i], be_q[i], data_q[i]);
                    i = i + 1;
                end
                "S": begin
                    issue_store(addr_q[i], be_q[i], data_q[i]);
                    i = i + 1;
                end
                default: begin
                    if (i + 1 < op_q.size() && op_q[i + 1] == "L") begin
                        issue_pair(i, i + 1);
                        i = i + 2;
                    end
                    else begin
                        $display("Paired store at entry %0d has no load after it", i);
                        other_count = other_count + 1;
                        i = i + 1;
                    end
                end
            endcase
        end
    endtask

    task automatic check_idle_state;
        check_value("read_ready", 32'(read_ready), 32'd1);
        check_value("write_ready", 32'(write_ready), 32'd1);
        check_value("read_data_valid", 32'(read_data_valid), 32'd0);
        check_value("write_done", 32'(write_done), 32'd0);
        check_value("mem_read_req", 32'(mem_read_req), 32'd0);
        check_value("mem_write_req", 32'(mem_write_req), 32'd0);
    endtask

    initial begin
        reset_n = 1'b0;
        read_req = 1'b0;
        read_addr = '0;
        read_byte_enable = '0;
        write_req = 1'b0;
        write_addr = '0;
        write_byte_enable = '0;
        write_data = '0;
        cycle_count = 0;
        check_count = 0;
        mismatch_count = 0;
        other_count = 0;
        valid_count = 0;
        done_count = 0;
        loads_issued = 0;
        stores_issued = 0;
        cycle_limit = 100;

        init_shadow();
        load_input();
        cycle_limit = 64 * op_q.size() + 100;

        repeat (16) @(posedge clk);
        #1;
        check_idle_state(); // Outputs as they leave reset
        reset_n = 1'b1;

        run_accesses();
        repeat (4) step();
        check_idle_state();
        check_value("read_data_valid pulses", valid_count, loads_issued);
        check_value("write_done pulses", done_count, stores_issued);

        $display("Checks: %0d, value mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("*** TEST PASSED ***");
        end
        else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: lsu_input.txt
# op addr byte_enable data. L load with data as the expected read data on enabled lanes,
# S store, P store issued in the same cycle as the load on the next line
L 00000010 f 85848786
L 00000021 f b2b5b4b7
L 00000033 3 0000a2a5
L 00000042 3 0000d5d4
L 00000047 1 000000d1
L 00000051 7 00c5c4c7
S 00000060 1 000000aa
L 00000060 f f5f4f7aa
S 00000064 c beef0000
L 00000064 f beeff3f2
S 00000072 3 0000cafe
L 00000070 f cafee7e6
S 00000083 f 11223344
L 00000080 f 44141716
L 00000084 f 11112233
L 00000083 f 11223344
S 0000009f 3 00005a6b
L 0000009e 3 00006b08
L 000000a0 f 3534375a
P 000000c0 f 0badf00d
L 000000b0 f 25242726
L 000000c0 f 0badf00d
P 000000d2 f a1b2c3d4
L 000000e1 f 72757477
L 000000d2 f a1b2c3d4

// File: sources.f
mem_pkg.sv
lsu_pkg.sv
read_buffer.sv
load_unit.sv
store_unit.sv
mem_port_arbiter.sv
load_store_unit.sv
tb_mem_model.sv
tb_load_store_unit.sv

// File: Makefile
VERILATOR = verilator
VERILATOR_FLAGS = --binary --timing --timescale 1ns/10ps -j 0
TOP = tb_load_store_unit
FILE_LIST = sources.f
BUILD_DIR = obj_dir
PASS_TEXT = *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
